//--- vec_cfg_pkg.sv
// Vector slice sizing constants
// Register file geometry, instruction id pool, scratch memory and unit latencies
package vec_cfg_pkg;

  // Register file geometry
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned NrElems   = 4;
  localparam int unsigned ElemWidth = 8;
  localparam int unsigned VRegWidth = NrElems * ElemWidth;

  // Pool of in-flight instruction ids, also bounds every PE queue
  localparam int unsigned NrVInsn  = 4;
  localparam int unsigned VidWidth = $clog2(NrVInsn);

  // PE indices on the done strobes
  localparam int unsigned NrPEs   = 2;
  localparam int unsigned PeArith = 0;
  localparam int unsigned PeLdst  = 1;

  // Scratch memory in 32-bit words
  localparam int unsigned MemWords    = 16;
  localparam int unsigned MemIdxWidth = $clog2(MemWords);

  // Cycles from start to retire
  localparam int unsigned ArithLatency  = 3;
  localparam int unsigned LdstLatency   = 2;
  localparam int unsigned ArithCntWidth = $clog2(ArithLatency);
  localparam int unsigned LdstCntWidth  = $clog2(LdstLatency);

  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [VidWidth-1:0]        vid_t;
  typedef logic [NrVInsn-1:0]         vmask_t;
  typedef logic [VRegWidth-1:0]       vreg_t;
  typedef logic [ArithCntWidth-1:0]   arith_cnt_t;
  typedef logic [LdstCntWidth-1:0]    ldst_cnt_t;

endpackage

//--- vec_isa_pkg.sv
// Vector instruction set
// Opcodes, unit selector, dispatcher and PE request formats
package vec_isa_pkg;

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMV_VX, // Broadcast low byte of the scalar
    VMV_XV, // Register to scalar, no destination
    VLE,
    VSE
  } vec_op_e;

  typedef enum logic {
    VFU_Arith,
    VFU_Ldst
  } vfu_e;

  // Request as it arrives from the dispatcher
  typedef struct packed {
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vs1;
    logic                   use_vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    logic                   use_vs2;
    vec_cfg_pkg::vreg_idx_t vd;
    logic                   use_vd;
    logic [31:0]            scalar_op;
  } vec_req_t;

  // Issued instruction with its id and the ids it must wait for
  typedef struct packed {
    vec_cfg_pkg::vid_t      id;
    vec_op_e                op;
    vfu_e                   vfu;
    vec_cfg_pkg::vreg_idx_t vs1;
    logic                   use_vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    logic                   use_vs2;
    vec_cfg_pkg::vreg_idx_t vd;
    logic                   use_vd;
    logic [31:0]            scalar_op;
    vec_cfg_pkg::vmask_t    hazard_vs1;
    vec_cfg_pkg::vmask_t    hazard_vs2;
    vec_cfg_pkg::vmask_t    hazard_vd;
  } pe_req_t;

  function automatic logic is_mem(vec_op_e op);
    return (op == VLE) || (op == VSE);
  endfunction

  // Loads, stores and scalar moves hold the dispatcher until a reply
  function automatic logic needs_reply(vec_op_e op);
    return is_mem(op) || (op == VMV_XV);
  endfunction

endpackage

//--- vec_pe_if.sv
// Sequencer to PE link
// Carries the issued instruction, the running id set and per-PE retire strobes
interface vec_pe_if;

  // One-cycle issue strobe, PEs never push back
  logic                 issue_valid;
  vec_isa_pkg::pe_req_t req;

  // Ids still in flight anywhere in the slice
  vec_cfg_pkg::vmask_t running;

  // Retire strobe and id, one pair per PE
  logic              done_valid [vec_cfg_pkg::NrPEs];
  vec_cfg_pkg::vid_t done_id    [vec_cfg_pkg::NrPEs];

  modport seq (
    output issue_valid, req, running,
    input  done_valid, done_id
  );

  modport pe (
    input  issue_valid, req, running,
    output done_valid, done_id
  );

endinterface

//--- vec_sequencer.sv
// Vector instruction sequencer
// Allocates ids, tracks register accesses, builds hazard masks and replies to the dispatcher
module vec_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vec_isa_pkg::vec_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output logic                  resp_valid_o,
  output logic [31:0]           resp_data_o,
  output logic                  resp_error_o,
  input  logic                  ldst_ack_i,
  input  logic                  ldst_error_i,
  input  logic                  scalar_valid_i,
  input  vec_cfg_pkg::vreg_t    scalar_i,
  vec_pe_if.seq                 pe
);

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  // Last writer of a register
  typedef struct packed {
    vec_cfg_pkg::vid_t vid;
    logic              valid;
  } vreg_access_t;

  state_e state_q, state_d;

  vec_cfg_pkg::vmask_t running_q, running_d;
  vec_cfg_pkg::vmask_t done_mask;
  vec_cfg_pkg::vmask_t next_onehot;
  vec_cfg_pkg::vid_t   next_id;
  logic                full;
  logic                accept;
  logic                reply;

  // Writer per register, readers as a mask so that every pending reader is seen
  vreg_access_t        write_list_q [vec_cfg_pkg::NrVRegs];
  vreg_access_t        write_list_d [vec_cfg_pkg::NrVRegs];
  vec_cfg_pkg::vmask_t read_mask_q  [vec_cfg_pkg::NrVRegs];
  vec_cfg_pkg::vmask_t read_mask_d  [vec_cfg_pkg::NrVRegs];

  vec_cfg_pkg::vmask_t  haz_vs1, haz_vs2, haz_vd;
  vec_isa_pkg::pe_req_t req_d, req_q;
  logic                 issue_valid_q;
  logic                 resp_valid_q;
  logic                 resp_error_q;
  logic [31:0]          resp_data_q;

  // Lowest free id
  always_comb begin
    next_id = '0;
    for (int i = vec_cfg_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id = vec_cfg_pkg::vid_t'(i);
    end
  end

  assign next_onehot = vec_cfg_pkg::vmask_t'(1) << next_id;
  assign full        = &running_q;

  // Stall on a full pool or while a reply is pending
  assign req_ready_o = (state_q == IDLE) && !full;
  assign accept      = req_valid_i && req_ready_o;
  assign reply       = (state_q == WAIT) && (ldst_ack_i || scalar_valid_i);

  // Retired ids from both PEs
  always_comb begin
    done_mask = '0;
    for (int p = 0; p < vec_cfg_pkg::NrPEs; p++) begin
      if (pe.done_valid[p]) done_mask[pe.done_id[p]] = 1'b1;
    end
  end

  assign running_d = (running_q & ~done_mask) | (accept ? next_onehot : '0);

  always_comb begin
    haz_vs1 = '0;
    haz_vs2 = '0;
    haz_vd  = '0;
    // Drop accesses of ids that already left
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) begin
      write_list_d[r]       = write_list_q[r];
      write_list_d[r].valid = write_list_q[r].valid && running_q[write_list_q[r].vid];
      read_mask_d[r]        = read_mask_q[r] & running_q;
    end
    // RAW on the sources
    if (req_i.use_vs1 && write_list_d[req_i.vs1].valid)
      haz_vs1[write_list_d[req_i.vs1].vid] = 1'b1;
    if (req_i.use_vs2 && write_list_d[req_i.vs2].valid)
      haz_vs2[write_list_d[req_i.vs2].vid] = 1'b1;
    // WAR and WAW on the destination
    if (req_i.use_vd) begin
      haz_vd = read_mask_d[req_i.vd];
      if (write_list_d[req_i.vd].valid) haz_vd[write_list_d[req_i.vd].vid] = 1'b1;
    end
    // Record the new access after the masks are taken
    if (accept) begin
      if (req_i.use_vd) write_list_d[req_i.vd] = '{vid: next_id, valid: 1'b1};
      if (req_i.use_vs1) read_mask_d[req_i.vs1] |= next_onehot;
      if (req_i.use_vs2) read_mask_d[req_i.vs2] |= next_onehot;
    end
  end

  assign req_d = '{
    id:         next_id,
    op:         req_i.op,
    vfu:        vec_isa_pkg::is_mem(req_i.op) ? vec_isa_pkg::VFU_Ldst : vec_isa_pkg::VFU_Arith,
    vs1:        req_i.vs1,
    use_vs1:    req_i.use_vs1,
    vs2:        req_i.vs2,
    use_vs2:    req_i.use_vs2,
    vd:         req_i.vd,
    use_vd:     req_i.use_vd,
    scalar_op:  req_i.scalar_op,
    hazard_vs1: haz_vs1,
    hazard_vs2: haz_vs2,
    hazard_vd:  haz_vd
  };

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (accept && vec_isa_pkg::needs_reply(req_i.op)) state_d = WAIT;
      WAIT: if (reply) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      running_q     <= '0;
      issue_valid_q <= 1'b0;
      resp_valid_q  <= 1'b0;
      for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) begin
        write_list_q[r] <= '0;
        read_mask_q[r]  <= '0;
      end
    end else begin
      state_q       <= state_d;
      running_q     <= running_d;
      issue_valid_q <= accept;
      resp_valid_q  <= reply;
      write_list_q  <= write_list_d;
      read_mask_q   <= read_mask_d;
    end
  end

  // Issued instruction and reply payload
  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_d;
    if (reply) begin
      resp_data_q  <= scalar_valid_i ? scalar_i : '0;
      resp_error_q <= ldst_ack_i && ldst_error_i;
    end
  end

  assign pe.issue_valid = issue_valid_q;
  assign pe.req         = req_q;
  assign pe.running     = running_q;

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  assign resp_error_o = resp_error_q;

endmodule

//--- vec_arith_unit.sv
// Arithmetic PE
// Owns the vector register file and runs byte-lane operations in order
module vec_arith_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  vec_pe_if.pe                   pe,
  input  vec_cfg_pkg::vreg_idx_t rd_idx_i,
  output vec_cfg_pkg::vreg_t     rd_data_o,
  input  logic                   wr_valid_i,
  input  vec_cfg_pkg::vreg_idx_t wr_idx_i,
  input  vec_cfg_pkg::vreg_t     wr_data_i,
  output logic                   scalar_valid_o,
  output vec_cfg_pkg::vreg_t     scalar_o
);

  vec_cfg_pkg::vreg_t   vreg_q [vec_cfg_pkg::NrVRegs];
  vec_isa_pkg::pe_req_t q_req  [vec_cfg_pkg::NrVInsn];
  vec_cfg_pkg::vmask_t  q_haz  [vec_cfg_pkg::NrVInsn];

  logic [vec_cfg_pkg::VidWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [vec_cfg_pkg::VidWidth:0]   count_q;
  logic                             busy_q;
  vec_cfg_pkg::arith_cnt_t          cnt_q;

  logic                 push, start, retire;
  vec_isa_pkg::pe_req_t head;
  vec_cfg_pkg::vreg_t   opa, opb, result;

  assign push   = pe.issue_valid && (pe.req.vfu == vec_isa_pkg::VFU_Arith);
  assign head   = q_req[rd_ptr_q];
  // Head starts once all ids it waits on have left the running set
  assign start  = !busy_q && (count_q != '0) && ((q_haz[rd_ptr_q] & pe.running) == '0);
  assign retire = busy_q && (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (retire) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !retire) count_q <= count_q + 1'b1;
      else if (!push && retire) count_q <= count_q - 1'b1;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= vec_cfg_pkg::arith_cnt_t'(vec_cfg_pkg::ArithLatency - 1);
      end else if (retire) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Hazard bits fall away as soon as their id is seen idle, so a reused id is never waited on
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < vec_cfg_pkg::NrVInsn; i++) q_haz[i] <= q_haz[i] & pe.running;
    if (push) begin
      q_req[wr_ptr_q] <= pe.req;
      q_haz[wr_ptr_q] <= (pe.req.hazard_vs1 | pe.req.hazard_vs2 | pe.req.hazard_vd) & pe.running;
    end
  end

  assign opa = vreg_q[head.vs1];
  assign opb = vreg_q[head.vs2];

  // Per-byte result, vs2 op vs1, wrapping
  always_comb begin
    result = '0;
    for (int e = 0; e < vec_cfg_pkg::NrElems; e++) begin
      logic [vec_cfg_pkg::ElemWidth-1:0] a, b, r;
      a = opa[e*vec_cfg_pkg::ElemWidth +: vec_cfg_pkg::ElemWidth];
      b = opb[e*vec_cfg_pkg::ElemWidth +: vec_cfg_pkg::ElemWidth];
      case (head.op)
        vec_isa_pkg::VADD:   r = b + a;
        vec_isa_pkg::VSUB:   r = b - a;
        vec_isa_pkg::VAND:   r = b & a;
        vec_isa_pkg::VOR:    r = b | a;
        vec_isa_pkg::VXOR:   r = b ^ a;
        vec_isa_pkg::VMV_VX: r = head.scalar_op[vec_cfg_pkg::ElemWidth-1:0];
        default:             r = b;
      endcase
      result[e*vec_cfg_pkg::ElemWidth +: vec_cfg_pkg::ElemWidth] = r;
    end
  end

  // Arithmetic write-back and load write port
  always_ff @(posedge clk_i) begin
    if (retire && head.use_vd) vreg_q[head.vd] <= result;
    if (wr_valid_i) vreg_q[wr_idx_i] <= wr_data_i;
  end

  // Store read port
  assign rd_data_o = vreg_q[rd_idx_i];

  assign scalar_valid_o = retire && (head.op == vec_isa_pkg::VMV_XV);
  assign scalar_o       = opb;

  assign pe.done_valid[vec_cfg_pkg::PeArith] = retire;
  assign pe.done_id[vec_cfg_pkg::PeArith]    = head.id;

endmodule

//--- vec_ldst_unit.sv
// Load/store PE
// Scratch memory with address check, in-order loads and stores over the register ports
module vec_ldst_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  vec_pe_if.pe                   pe,
  output vec_cfg_pkg::vreg_idx_t rd_idx_o,
  input  vec_cfg_pkg::vreg_t     rd_data_i,
  output logic                   wr_valid_o,
  output vec_cfg_pkg::vreg_idx_t wr_idx_o,
  output vec_cfg_pkg::vreg_t     wr_data_o,
  output logic                   ack_o,
  output logic                   error_o
);

  vec_cfg_pkg::vreg_t   mem_q [vec_cfg_pkg::MemWords];
  vec_isa_pkg::pe_req_t q_req [vec_cfg_pkg::NrVInsn];
  vec_cfg_pkg::vmask_t  q_haz [vec_cfg_pkg::NrVInsn];

  logic [vec_cfg_pkg::VidWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [vec_cfg_pkg::VidWidth:0]   count_q;
  logic                             busy_q;
  vec_cfg_pkg::ldst_cnt_t           cnt_q;

  logic                                push, start, retire;
  vec_isa_pkg::pe_req_t                head;
  logic [31:0]                         addr;
  logic                                addr_err;
  logic [vec_cfg_pkg::MemIdxWidth-1:0] word_idx;

  assign push   = pe.issue_valid && (pe.req.vfu == vec_isa_pkg::VFU_Ldst);
  assign head   = q_req[rd_ptr_q];
  assign start  = !busy_q && (count_q != '0) && ((q_haz[rd_ptr_q] & pe.running) == '0);
  assign retire = busy_q && (cnt_q == '0);

  // Byte address, must be word aligned and inside the memory
  assign addr     = head.scalar_op;
  assign addr_err = (addr[1:0] != 2'b00) || ((addr >> 2) >= 32'(vec_cfg_pkg::MemWords));
  assign word_idx = addr[2 +: vec_cfg_pkg::MemIdxWidth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      for (int w = 0; w < vec_cfg_pkg::MemWords; w++) mem_q[w] <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (retire) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !retire) count_q <= count_q + 1'b1;
      else if (!push && retire) count_q <= count_q - 1'b1;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= vec_cfg_pkg::ldst_cnt_t'(vec_cfg_pkg::LdstLatency - 1);
      end else if (retire) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Faulting stores leave memory untouched
      if (retire && !addr_err && (head.op == vec_isa_pkg::VSE)) mem_q[word_idx] <= rd_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < vec_cfg_pkg::NrVInsn; i++) q_haz[i] <= q_haz[i] & pe.running;
    if (push) begin
      q_req[wr_ptr_q] <= pe.req;
      q_haz[wr_ptr_q] <= (pe.req.hazard_vs1 | pe.req.hazard_vs2 | pe.req.hazard_vd) & pe.running;
    end
  end

  // Store data comes from vs2, loads write vd on retire
  assign rd_idx_o   = head.vs2;
  assign wr_valid_o = retire && !addr_err && (head.op == vec_isa_pkg::VLE);
  assign wr_idx_o   = head.vd;
  assign wr_data_o  = mem_q[word_idx];

  // Acknowledge lines up with the done strobe
  assign ack_o   = retire;
  assign error_o = retire && addr_err;

  assign pe.done_valid[vec_cfg_pkg::PeLdst] = retire;
  assign pe.done_id[vec_cfg_pkg::PeLdst]    = head.id;

endmodule

//--- vec_top.sv
// Vector slice top level
// Sequencer, arithmetic PE and load/store PE behind a flat dispatcher port
module vec_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  vec_isa_pkg::vec_op_e   req_op_i,
  input  vec_cfg_pkg::vreg_idx_t req_vs1_i,
  input  logic                   req_use_vs1_i,
  input  vec_cfg_pkg::vreg_idx_t req_vs2_i,
  input  logic                   req_use_vs2_i,
  input  vec_cfg_pkg::vreg_idx_t req_vd_i,
  input  logic                   req_use_vd_i,
  input  logic [31:0]            req_scalar_i,
  output logic                   resp_valid_o,
  output logic [31:0]            resp_data_o,
  output logic                   resp_error_o
);

  vec_isa_pkg::vec_req_t  req;
  vec_cfg_pkg::vreg_idx_t rd_idx, wr_idx;
  vec_cfg_pkg::vreg_t     rd_data, wr_data, scalar;
  logic                   wr_valid, ldst_ack, ldst_error, scalar_valid;

  vec_pe_if pe_if ();

  assign req = '{
    op:        req_op_i,
    vs1:       req_vs1_i,
    use_vs1:   req_use_vs1_i,
    vs2:       req_vs2_i,
    use_vs2:   req_use_vs2_i,
    vd:        req_vd_i,
    use_vd:    req_use_vd_i,
    scalar_op: req_scalar_i
  };

  vec_sequencer i_sequencer (
    .clk_i,
    .rst_ni,
    .req_i          (req),
    .req_valid_i,
    .req_ready_o,
    .resp_valid_o,
    .resp_data_o,
    .resp_error_o,
    .ldst_ack_i     (ldst_ack),
    .ldst_error_i   (ldst_error),
    .scalar_valid_i (scalar_valid),
    .scalar_i       (scalar),
    .pe             (pe_if.seq)
  );

  vec_arith_unit i_arith (
    .clk_i,
    .rst_ni,
    .pe             (pe_if.pe),
    .rd_idx_i       (rd_idx),
    .rd_data_o      (rd_data),
    .wr_valid_i     (wr_valid),
    .wr_idx_i       (wr_idx),
    .wr_data_i      (wr_data),
    .scalar_valid_o (scalar_valid),
    .scalar_o       (scalar)
  );

  vec_ldst_unit i_ldst (
    .clk_i,
    .rst_ni,
    .pe         (pe_if.pe),
    .rd_idx_o   (rd_idx),
    .rd_data_i  (rd_data),
    .wr_valid_o (wr_valid),
    .wr_idx_o   (wr_idx),
    .wr_data_o  (wr_data),
    .ack_o      (ldst_ack),
    .error_o    (ldst_error)
  );

endmodule

//--- tb_vec_assertions.sv
// Sequencer protocol checks
// Issue timing, reply stall, id reuse and reply strobe width
module tb_vec_assertions (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input vec_isa_pkg::vec_op_e req_op_i,
  input vec_cfg_pkg::vid_t    next_id_i,
  input vec_cfg_pkg::vmask_t  running_i,
  input logic                 issue_valid_i,
  input logic                 resp_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench top
  int unsigned fail_cnt = 0;

  logic accept;
  logic reply_pending_q;

  assign accept = req_valid_i && req_ready_i;

  // Set on accept of a load, store or scalar move, cleared by the reply strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reply_pending_q <= 1'b0;
    end else if (accept && vec_isa_pkg::needs_reply(req_op_i)) begin
      reply_pending_q <= 1'b1;
    end else if (resp_valid_i) begin
      reply_pending_q <= 1'b0;
    end
  end

  issue_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> issue_valid_i)
    else begin
      $error("issue strobe missing one cycle after accept");
      fail_cnt++;
    end

  ready_low_on_reply: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (reply_pending_q && !resp_valid_i) |-> !req_ready_i)
    else begin
      $error("dispatcher ready while a reply is pending");
      fail_cnt++;
    end

  // Allocated id must be idle
  free_vid_on_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !running_i[next_id_i])
    else begin
      $error("vid allocated while still running");
      fail_cnt++;
    end

  resp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> !resp_valid_i)
    else begin
      $error("reply strobe longer than one cycle");
      fail_cnt++;
    end

endmodule

//--- tb_vec_top.sv
// Vector slice testbench
// Random lane ops, hazard chains, address faults and id pool exhaustion against a reference model
module tb_vec_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned WaitLimit   = 100;
  localparam int unsigned ResetCycles = 8;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_valid;
  logic                   req_ready;
  vec_isa_pkg::vec_op_e   req_op;
  vec_cfg_pkg::vreg_idx_t req_vs1, req_vs2, req_vd;
  logic                   req_use_vs1, req_use_vs2, req_use_vd;
  logic [31:0]            req_scalar;
  logic                   resp_valid;
  logic [31:0]            resp_data;
  logic                   resp_error;

  // Reference state, memory starts at zero like the DUT scratch memory
  logic [31:0] ref_vreg [vec_cfg_pkg::NrVRegs];
  logic [31:0] ref_mem  [vec_cfg_pkg::MemWords];

  logic [15:0] lfsr_q       = 16'd92;
  int unsigned checks       = 0;
  int unsigned errors       = 0;
  int unsigned stall_cycles = 0;
  logic        timed_out    = 1'b0;

  vec_top DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_op_i      (req_op),
    .req_vs1_i     (req_vs1),
    .req_use_vs1_i (req_use_vs1),
    .req_vs2_i     (req_vs2),
    .req_use_vs2_i (req_use_vs2),
    .req_vd_i      (req_vd),
    .req_use_vd_i  (req_use_vd),
    .req_scalar_i  (req_scalar),
    .resp_valid_o  (resp_valid),
    .resp_data_o   (resp_data),
    .resp_error_o  (resp_error)
  );

  bind vec_sequencer tb_vec_assertions u_seq_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_i   (req_ready_o),
    .req_op_i      (req_i.op),
    .next_id_i     (next_id),
    .running_i     (running_q),
    .issue_valid_i (issue_valid_q),
    .resp_valid_i  (resp_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic vec_cfg_pkg::vreg_idx_t pick_reg();
    return vec_cfg_pkg::vreg_idx_t'(rand_bits(3));
  endfunction

  function automatic logic [7:0] pick_byte();
    return 8'(rand_bits(8));
  endfunction

  function automatic vec_isa_pkg::vec_op_e lane_op(int unsigned k);
    case (k % 5)
      0:       return vec_isa_pkg::VADD;
      1:       return vec_isa_pkg::VSUB;
      2:       return vec_isa_pkg::VAND;
      3:       return vec_isa_pkg::VOR;
      default: return vec_isa_pkg::VXOR;
    endcase
  endfunction

  // Per-byte result of vs2 op vs1, wrapping at 8 bits
  function automatic logic [31:0] expect_lanes(vec_isa_pkg::vec_op_e op, logic [31:0] src2,
                                               logic [31:0] src1);
    logic [31:0] r;
    logic [7:0]  a, b;
    r = '0;
    for (int e = 0; e < vec_cfg_pkg::NrElems; e++) begin
      a = src1[e*8 +: 8];
      b = src2[e*8 +: 8];
      case (op)
        vec_isa_pkg::VADD: r[e*8 +: 8] = b + a;
        vec_isa_pkg::VSUB: r[e*8 +: 8] = b - a;
        vec_isa_pkg::VAND: r[e*8 +: 8] = b & a;
        vec_isa_pkg::VOR:  r[e*8 +: 8] = b | a;
        default:           r[e*8 +: 8] = b ^ a;
      endcase
    end
    return r;
  endfunction

  // Misaligned, or past the last scratch word
  function automatic logic addr_faults(logic [31:0] addr);
    return (addr % 32'd4 != 32'd0) || (addr >= 32'(4 * vec_cfg_pkg::MemWords));
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (timed_out) return;
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Hold the request from a falling edge until ready was seen at a falling edge
  task automatic send_req(
    input vec_isa_pkg::vec_op_e   op,
    input vec_cfg_pkg::vreg_idx_t vs1,
    input logic                   use_vs1,
    input vec_cfg_pkg::vreg_idx_t vs2,
    input logic                   use_vs2,
    input vec_cfg_pkg::vreg_idx_t vd,
    input logic                   use_vd,
    input logic [31:0]            scalar
  );
    int unsigned waited;
    waited = 0;
    if (timed_out) return;
    req_op      = op;
    req_vs1     = vs1;
    req_use_vs1 = use_vs1;
    req_vs2     = vs2;
    req_use_vs2 = use_vs2;
    req_vd      = vd;
    req_use_vd  = use_vd;
    req_scalar  = scalar;
    req_valid   = 1'b1;
    while (!req_ready && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
      stall_cycles++;
    end
    if (!req_ready) begin
      $display("Timeout: dispatcher request not accepted within %0d cycles", WaitLimit);
      timed_out = 1'b1;
      req_valid = 1'b0;
      return;
    end
    // Accepted on the rising edge in between
    @(negedge clk_i);
    req_valid = 1'b0;
  endtask

  task automatic wait_reply(output logic [31:0] data, output logic err);
    int unsigned waited;
    waited = 0;
    data   = '0;
    err    = 1'b0;
    if (timed_out) return;
    while (!resp_valid && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!resp_valid) begin
      $display("Timeout: no reply from the DUT within %0d cycles", WaitLimit);
      timed_out = 1'b1;
      return;
    end
    data = resp_data;
    err  = resp_error;
  endtask

  task automatic bcast(input vec_cfg_pkg::vreg_idx_t vd, input logic [7:0] val);
    send_req(vec_isa_pkg::VMV_VX, '0, 1'b0, '0, 1'b0, vd, 1'b1, {24'h0, val});
    if (!timed_out) ref_vreg[vd] = {vec_cfg_pkg::NrElems{val}};
  endtask

  task automatic lane_arith(input vec_isa_pkg::vec_op_e op, input vec_cfg_pkg::vreg_idx_t vd,
                            input vec_cfg_pkg::vreg_idx_t vs1, input vec_cfg_pkg::vreg_idx_t vs2);
    send_req(op, vs1, 1'b1, vs2, 1'b1, vd, 1'b1, '0);
    if (!timed_out) ref_vreg[vd] = expect_lanes(op, ref_vreg[vs2], ref_vreg[vs1]);
  endtask

  // Read a register back as a scalar and compare with the model
  task automatic check_reg(input vec_cfg_pkg::vreg_idx_t idx);
    logic [31:0] data;
    logic        err;
    send_req(vec_isa_pkg::VMV_XV, '0, 1'b0, idx, 1'b1, '0, 1'b0, '0);
    wait_reply(data, err);
    check_value($sformatf("v%0d readback", idx), data, ref_vreg[idx]);
    check_value($sformatf("v%0d readback error flag", idx), 32'(err), 32'd0);
  endtask

  task automatic store_reg(input vec_cfg_pkg::vreg_idx_t vs2, input logic [31:0] addr);
    logic [31:0] data;
    logic        err;
    logic        bad;
    bad = addr_faults(addr);
    send_req(vec_isa_pkg::VSE, '0, 1'b0, vs2, 1'b1, '0, 1'b0, addr);
    wait_reply(data, err);
    check_value($sformatf("VSE to %h error flag", addr), 32'(err), 32'(bad));
    if (!bad && !timed_out) ref_mem[addr[2 +: vec_cfg_pkg::MemIdxWidth]] = ref_vreg[vs2];
  endtask

  // Faulting loads leave the destination as it was
  task automatic load_reg(input vec_cfg_pkg::vreg_idx_t vd, input logic [31:0] addr);
    logic [31:0] data;
    logic        err;
    logic        bad;
    bad = addr_faults(addr);
    send_req(vec_isa_pkg::VLE, '0, 1'b0, '0, 1'b0, vd, 1'b1, addr);
    wait_reply(data, err);
    check_value($sformatf("VLE from %h error flag", addr), 32'(err), 32'(bad));
    if (!bad && !timed_out) ref_vreg[vd] = ref_mem[addr[2 +: vec_cfg_pkg::MemIdxWidth]];
  endtask

  task automatic report_test(input int num, input string name, input int unsigned err0,
                             input int unsigned chk0);
    $display("Test %0d %s: %s, %0d checks, %0d errors", num, name,
             (errors == err0 && !timed_out) ? "passed" : "failed", checks - chk0, errors - err0);
  endtask

  task automatic test_lane_ops();
    int unsigned            e0, c0;
    vec_cfg_pkg::vreg_idx_t vs1, vs2, vd;
    e0 = errors;
    c0 = checks;
    // Known content in every register first, which also covers VMV_VX
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) bcast(vec_cfg_pkg::vreg_idx_t'(r), pick_byte());
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) check_reg(vec_cfg_pkg::vreg_idx_t'(r));
    for (int round = 0; round < 3; round++) begin
      for (int k = 0; k < 5; k++) begin
        vs1 = pick_reg();
        vs2 = pick_reg();
        vd  = pick_reg();
        bcast(vs1, pick_byte());
        bcast(vs2, pick_byte());
        lane_arith(lane_op(k), vd, vs1, vs2);
        check_reg(vd);
      end
    end
    report_test(1, "lane ops", e0, c0);
  endtask

  task automatic test_raw_chain();
    int unsigned            e0, c0;
    vec_cfg_pkg::vreg_idx_t a, b, c, d;
    logic [31:0]            addr;
    e0   = errors;
    c0   = checks;
    a    = pick_reg();
    b    = a + 3'd1;
    c    = a + 3'd2;
    d    = a + 3'd3;
    addr = {26'd0, 4'(rand_bits(4)), 2'b00};
    bcast(d, pick_byte());
    // Store waits on the broadcast still in the arithmetic unit
    bcast(a, pick_byte());
    store_reg(a, addr);
    // Add reads the register the load just wrote
    load_reg(b, addr);
    lane_arith(vec_isa_pkg::VADD, c, b, d);
    check_reg(c);
    check_reg(b);
    report_test(2, "RAW chain", e0, c0);
  endtask

  task automatic test_war_store();
    int unsigned            e0, c0;
    vec_cfg_pkg::vreg_idx_t a, c, f;
    logic [31:0]            addr;
    e0   = errors;
    c0   = checks;
    a    = pick_reg();
    c    = a + 3'd2;
    f    = a + 3'd4;
    addr = {26'd0, 4'(rand_bits(4)), 2'b00};
    bcast(a, pick_byte());
    store_reg(a, addr);
    bcast(a, pick_byte());
    // Memory must hold the value before the overwrite
    load_reg(f, addr);
    check_reg(f);
    check_reg(a);
    // Arithmetic reader still queued behind its source writer
    // when a load overwrites that source
    bcast(a, pick_byte());
    lane_arith(vec_isa_pkg::VXOR, c, a, f);
    load_reg(a, addr);
    check_reg(c);
    check_reg(a);
    report_test(3, "WAR store", e0, c0);
  endtask

  task automatic test_addr_fault();
    int unsigned            e0, c0;
    vec_cfg_pkg::vreg_idx_t d, s;
    logic [3:0]             k;
    e0 = errors;
    c0 = checks;
    d  = pick_reg();
    s  = d + 3'd1;
    k  = 4'(rand_bits(4));
    bcast(s, pick_byte());
    store_reg(s, {26'd0, k, 2'b00});
    load_reg(d, {26'd0, k, 2'b10});
    check_reg(d);
    // Out of range, the low bits alias word k
    load_reg(d, 32'd64 + {26'd0, k, 2'b00});
    check_reg(d);
    load_reg(d, 32'hFFFF_FFF0);
    check_reg(d);
    // Faulting stores must not touch word k
    bcast(s, pick_byte());
    store_reg(s, 32'd64 + {26'd0, k, 2'b00});
    store_reg(s, {26'd0, k, 2'b01});
    load_reg(d, {26'd0, k, 2'b00});
    check_reg(d);
    report_test(4, "address faults", e0, c0);
  endtask

  task automatic test_id_pool();
    int unsigned e0, c0, s0;
    e0 = errors;
    c0 = checks;
    s0 = stall_cycles;
    // Back to back non-reply instructions outrun the arithmetic latency
    for (int i = 0; i < 12; i++) begin
      if (i % 3 == 0) bcast(pick_reg(), pick_byte());
      else lane_arith(lane_op(rand_bits(3)), pick_reg(), pick_reg(), pick_reg());
    end
    if (!timed_out) begin
      checks++;
      assert (stall_cycles > s0) else begin
        errors++;
        $display("Error at %0d ns: req_ready_o never dropped during the burst", $time);
      end
    end
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) check_reg(vec_cfg_pkg::vreg_idx_t'(r));
    report_test(5, "id pool full", e0, c0);
  endtask

  initial begin
    int unsigned assert_fails;
    rst_ni      = 1'b0;
    req_valid   = 1'b0;
    req_op      = vec_isa_pkg::VADD;
    req_vs1     = '0;
    req_use_vs1 = 1'b0;
    req_vs2     = '0;
    req_use_vs2 = 1'b0;
    req_vd      = '0;
    req_use_vd  = 1'b0;
    req_scalar  = '0;
    for (int w = 0; w < vec_cfg_pkg::MemWords; w++) ref_mem[w] = '0;
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) ref_vreg[r] = '0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_lane_ops();
    test_raw_chain();
    test_war_store();
    test_addr_fault();
    test_id_pool();
    assert_fails = DUT.i_sequencer.u_seq_assert.fail_cnt;
    $display("Summary: 5 tests, %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
vec_cfg_pkg.sv
vec_isa_pkg.sv
vec_pe_if.sv
vec_sequencer.sv
vec_arith_unit.sv
vec_ldst_unit.sv
vec_top.sv
tb_vec_assertions.sv
tb_vec_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the vector slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vec_top -f build.f

# Raise the error limit so that assertion failures do not stop the run early
output=$(./obj_dir/Vtb_vec_top +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
